// ==== hw/core_region_macros.svh ====
`ifndef CORE_REGION_MACROS_SVH
`define CORE_REGION_MACROS_SVH

// core load/store port
`define CR_ADDR_W        32
`define CR_CORE_DATA_W   32
`define CR_CORE_BE_W     4

// ram and bulk port word
`define CR_WORD_W        64
`define CR_WORD_BE_W     8
`define CR_WORD_OFFS_W   3

// 4 KiB of 64-bit words
`define CR_RAM_BYTES     4096
`define CR_RAM_ADDR_W    12
`define CR_RAM_DEPTH     512

// address bits that pick the region
`define CR_REGION_MSB    31
`define CR_REGION_LSB    20

// region tag that maps to the local data ram
`define CR_LOCAL_REGION  12'h001

`endif

// ==== hw/core_region_pkg.sv ====
`include "core_region_macros.svh"

package core_region_pkg;

  // one ram word, seen either whole or as two core-sized halves
  // half[1] sits in the upper 32 bits
  typedef union packed {
    logic [`CR_WORD_W-1:0]                word;
    logic [1:0][`CR_CORE_DATA_W-1:0]      half;
  } ram_word_u;

  // the halves must tile the word exactly
  localparam int unsigned RAM_HALVES = `CR_WORD_W / `CR_CORE_DATA_W;

  // bytes per ram word, used for the byte lanes
  localparam int unsigned RAM_WORD_BYTES = `CR_WORD_BE_W;

  // word count follows from the byte size
  localparam int unsigned RAM_WORDS = `CR_RAM_BYTES / RAM_WORD_BYTES;

endpackage

// ==== hw/sp_ram.sv ====
`include "core_region_macros.svh"

module sp_ram
  import core_region_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     en_i,
  input  logic [`CR_RAM_ADDR_W-`CR_WORD_OFFS_W-1:0] addr_i,
  input  logic                                     we_i,
  input  logic [`CR_WORD_BE_W-1:0]                 be_i,
  input  ram_word_u                                wdata_i,
  output ram_word_u                                rdata_o
);

  // words stored as byte lanes
  logic [`CR_WORD_BE_W-1:0][7:0] mem [`CR_RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int i = 0; i < `CR_WORD_BE_W; i++) begin
          if (be_i[i]) begin
            mem[addr_i][i] <= wdata_i.word[8*i +: 8];
          end
        end
      end
      // read-first, old contents come back on a write
      rdata_o.word <= mem[addr_i];
    end
  end

  // the mux must present a clean address whenever it enables the ram
  a_addr_known: assert property (
    @(posedge clk) en_i |-> !$isunknown(addr_i)
  );

endmodule

// ==== hw/ram_mux.sv ====
`include "core_region_macros.svh"

module ram_mux
  import core_region_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst_n,

  // bulk port with word addresses and no grant
  input  logic                                     bulk_req_i,
  input  logic [`CR_RAM_ADDR_W-`CR_WORD_OFFS_W-1:0] bulk_addr_i,
  input  logic                                     bulk_we_i,
  input  logic [`CR_WORD_BE_W-1:0]                 bulk_be_i,
  input  logic [`CR_WORD_W-1:0]                    bulk_wdata_i,
  output logic [`CR_WORD_W-1:0]                    bulk_rdata_o,

  // byte-addressed core port
  input  logic                                     core_req_i,
  input  logic [`CR_RAM_ADDR_W-1:0]                core_addr_i,
  input  logic                                     core_we_i,
  input  logic [`CR_CORE_BE_W-1:0]                 core_be_i,
  input  logic [`CR_CORE_DATA_W-1:0]               core_wdata_i,
  output logic                                     core_gnt_o,
  output logic                                     core_rvalid_o,
  output logic [`CR_CORE_DATA_W-1:0]               core_rdata_o,

  // ram side
  output logic                                     ram_en_o,
  output logic [`CR_RAM_ADDR_W-`CR_WORD_OFFS_W-1:0] ram_addr_o,
  output logic                                     ram_we_o,
  output logic [`CR_WORD_BE_W-1:0]                 ram_be_o,
  output ram_word_u                                ram_wdata_o,
  input  ram_word_u                                ram_rdata_i
);

  logic                       core_half;
  logic [`CR_WORD_BE_W-1:0]   core_be_word;
  ram_word_u                  core_word;
  logic                       core_rvalid_q;
  logic                       core_half_q;

  // byte address bit 2 picks the 32-bit half
  assign core_half = core_addr_i[`CR_WORD_OFFS_W-1];

  always_comb begin
    core_be_word = '0;
    if (core_half) begin
      core_be_word[`CR_WORD_BE_W-1:`CR_CORE_BE_W] = core_be_i;
    end else begin
      core_be_word[`CR_CORE_BE_W-1:0] = core_be_i;
    end
  end

  // core data copied into both halves
  // the byte enables pick the half that lands
  always_comb begin
    core_word.half[0] = core_wdata_i;
    core_word.half[1] = core_wdata_i;
  end

  // bulk port has fixed priority over the core
  assign core_gnt_o = core_req_i & ~bulk_req_i;
  assign ram_en_o   = bulk_req_i | core_req_i;

  always_comb begin
    if (bulk_req_i) begin
      ram_addr_o       = bulk_addr_i;
      ram_we_o         = bulk_we_i;
      ram_be_o         = bulk_be_i;
      ram_wdata_o.word = bulk_wdata_i;
    end else begin
      ram_addr_o  = core_addr_i[`CR_RAM_ADDR_W-1:`CR_WORD_OFFS_W];
      ram_we_o    = core_we_i;
      ram_be_o    = core_be_word;
      ram_wdata_o = core_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_q <= 1'b0;
      core_half_q   <= 1'b0;
    end else begin
      core_rvalid_q <= core_gnt_o;
      if (core_gnt_o) begin
        core_half_q <= core_half;
      end
    end
  end

  assign core_rvalid_o = core_rvalid_q;
  assign core_rdata_o  = ram_rdata_i.half[core_half_q];
  assign bulk_rdata_o  = ram_rdata_i.word;

  // a core request held off by the bulk port stays up with the same address
  a_core_req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
      core_req_i && !core_gnt_o |=> core_req_i && $stable(core_addr_i)
  );

endmodule

// ==== hw/lsu_demux.sv ====
`include "core_region_macros.svh"

module lsu_demux (
  input  logic                        clk,
  input  logic                        rst_n,

  // core load/store port
  input  logic                        lsu_req_i,
  input  logic [`CR_ADDR_W-1:0]       lsu_addr_i,
  input  logic                        lsu_we_i,
  input  logic [`CR_CORE_BE_W-1:0]    lsu_be_i,
  input  logic [`CR_CORE_DATA_W-1:0]  lsu_wdata_i,
  output logic                        lsu_gnt_o,
  output logic                        lsu_rvalid_o,
  output logic [`CR_CORE_DATA_W-1:0]  lsu_rdata_o,

  // local ram side
  output logic                        ram_req_o,
  output logic [`CR_RAM_ADDR_W-1:0]   ram_addr_o,
  output logic                        ram_we_o,
  output logic [`CR_CORE_BE_W-1:0]    ram_be_o,
  output logic [`CR_CORE_DATA_W-1:0]  ram_wdata_o,
  input  logic                        ram_gnt_i,
  input  logic                        ram_rvalid_i,
  input  logic [`CR_CORE_DATA_W-1:0]  ram_rdata_i,

  // external bus side
  output logic                        ext_req_o,
  output logic [`CR_ADDR_W-1:0]       ext_addr_o,
  output logic                        ext_we_o,
  output logic [`CR_CORE_BE_W-1:0]    ext_be_o,
  output logic [`CR_CORE_DATA_W-1:0]  ext_wdata_o,
  input  logic                        ext_gnt_i,
  input  logic                        ext_rvalid_i,
  input  logic [`CR_CORE_DATA_W-1:0]  ext_rdata_i
);

  typedef enum logic {
    RESP_EXT = 1'b0,
    RESP_RAM = 1'b1
  } resp_src_e;

  logic      is_local;
  resp_src_e resp_q;
  resp_src_e resp_d;

  assign is_local  = (lsu_addr_i[`CR_REGION_MSB:`CR_REGION_LSB] == `CR_LOCAL_REGION);
  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // fields go to both sides, only the strobe is steered
  assign ram_addr_o  = lsu_addr_i[`CR_RAM_ADDR_W-1:0];
  assign ram_we_o    = lsu_we_i;
  assign ram_be_o    = lsu_be_i;
  assign ram_wdata_o = lsu_wdata_i;

  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  // grant from the addressed side, and note where the response will come from
  always_comb begin
    resp_d    = resp_q;
    lsu_gnt_o = 1'b0;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      if (ext_gnt_i) begin
        resp_d = RESP_EXT;
      end
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      if (ram_gnt_i) begin
        resp_d = RESP_RAM;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_q <= RESP_RAM;
    end else begin
      resp_q <= resp_d;
    end
  end

  assign lsu_rdata_o  = (resp_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;

  // the lsu only switches region once its responses are back
  a_single_resp_src: assert property (
    @(posedge clk) disable iff (!rst_n) !(ram_rvalid_i && ext_rvalid_i)
  );

endmodule

// ==== hw/data_region.sv ====
`include "core_region_macros.svh"

module data_region
  import core_region_pkg::*;
(
  input  logic                                     clk,
  input  logic                                     rst_n,

  // core load/store port
  input  logic                                     lsu_req_i,
  input  logic [`CR_ADDR_W-1:0]                    lsu_addr_i,
  input  logic                                     lsu_we_i,
  input  logic [`CR_CORE_BE_W-1:0]                 lsu_be_i,
  input  logic [`CR_CORE_DATA_W-1:0]               lsu_wdata_i,
  output logic                                     lsu_gnt_o,
  output logic                                     lsu_rvalid_o,
  output logic [`CR_CORE_DATA_W-1:0]               lsu_rdata_o,

  // external bus
  output logic                                     ext_req_o,
  output logic [`CR_ADDR_W-1:0]                    ext_addr_o,
  output logic                                     ext_we_o,
  output logic [`CR_CORE_BE_W-1:0]                 ext_be_o,
  output logic [`CR_CORE_DATA_W-1:0]               ext_wdata_o,
  input  logic                                     ext_gnt_i,
  input  logic                                     ext_rvalid_i,
  input  logic [`CR_CORE_DATA_W-1:0]               ext_rdata_i,

  // bulk port
  input  logic                                     bulk_req_i,
  input  logic [`CR_RAM_ADDR_W-`CR_WORD_OFFS_W-1:0] bulk_addr_i,
  input  logic                                     bulk_we_i,
  input  logic [`CR_WORD_BE_W-1:0]                 bulk_be_i,
  input  logic [`CR_WORD_W-1:0]                    bulk_wdata_i,
  output logic [`CR_WORD_W-1:0]                    bulk_rdata_o
);

  // demux to ram mux
  logic                                     ram_req;
  logic [`CR_RAM_ADDR_W-1:0]                ram_addr;
  logic                                     ram_we;
  logic [`CR_CORE_BE_W-1:0]                 ram_be;
  logic [`CR_CORE_DATA_W-1:0]               ram_wdata;
  logic                                     ram_gnt;
  logic                                     ram_rvalid;
  logic [`CR_CORE_DATA_W-1:0]               ram_rdata;

  // ram mux to ram
  logic                                     mem_en;
  logic [`CR_RAM_ADDR_W-`CR_WORD_OFFS_W-1:0] mem_addr;
  logic                                     mem_we;
  logic [`CR_WORD_BE_W-1:0]                 mem_be;
  ram_word_u                                mem_wdata;
  ram_word_u                                mem_rdata;

  lsu_demux u_demux (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ram_req_o    (ram_req),
    .ram_addr_o   (ram_addr),
    .ram_we_o     (ram_we),
    .ram_be_o     (ram_be),
    .ram_wdata_o  (ram_wdata),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .ext_req_o    (ext_req_o),
    .ext_addr_o   (ext_addr_o),
    .ext_we_o     (ext_we_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i)
  );

  ram_mux u_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .bulk_req_i    (bulk_req_i),
    .bulk_addr_i   (bulk_addr_i),
    .bulk_we_i     (bulk_we_i),
    .bulk_be_i     (bulk_be_i),
    .bulk_wdata_i  (bulk_wdata_i),
    .bulk_rdata_o  (bulk_rdata_o),
    .core_req_i    (ram_req),
    .core_addr_i   (ram_addr),
    .core_we_i     (ram_we),
    .core_be_i     (ram_be),
    .core_wdata_i  (ram_wdata),
    .core_gnt_o    (ram_gnt),
    .core_rvalid_o (ram_rvalid),
    .core_rdata_o  (ram_rdata),
    .ram_en_o      (mem_en),
    .ram_addr_o    (mem_addr),
    .ram_we_o      (mem_we),
    .ram_be_o      (mem_be),
    .ram_wdata_o   (mem_wdata),
    .ram_rdata_i   (mem_rdata)
  );

  sp_ram u_ram (
    .clk     (clk),
    .en_i    (mem_en),
    .addr_i  (mem_addr),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// ==== tb/tb_data_region.sv ====
`include "core_region_macros.svh"

module tb_data_region;

  localparam int PERIOD     = 100;
  localparam int QTR        = PERIOD / 4;
  localparam int WAIT_LIMIT = 20;
  localparam int WORD_AW    = `CR_RAM_ADDR_W - `CR_WORD_OFFS_W;

  // one stimulus row, exp only matters for local and bulk reads
  typedef struct packed {
    logic                     bulk;
    logic                     we;
    logic [`CR_ADDR_W-1:0]    addr;
    logic [`CR_WORD_BE_W-1:0] be;
    logic [`CR_WORD_W-1:0]    wdata;
    logic [`CR_WORD_W-1:0]    exp;
  } entry_t;

  logic                         clk;
  logic                         rst_n;
  logic                         lsu_req_i;
  logic [`CR_ADDR_W-1:0]        lsu_addr_i;
  logic                         lsu_we_i;
  logic [`CR_CORE_BE_W-1:0]     lsu_be_i;
  logic [`CR_CORE_DATA_W-1:0]   lsu_wdata_i;
  logic                         lsu_gnt_o;
  logic                         lsu_rvalid_o;
  logic [`CR_CORE_DATA_W-1:0]   lsu_rdata_o;
  logic                         ext_req_o;
  logic [`CR_ADDR_W-1:0]        ext_addr_o;
  logic                         ext_we_o;
  logic [`CR_CORE_BE_W-1:0]     ext_be_o;
  logic [`CR_CORE_DATA_W-1:0]   ext_wdata_o;
  logic                         ext_gnt_i;
  logic                         ext_rvalid_i;
  logic [`CR_CORE_DATA_W-1:0]   ext_rdata_i;
  logic                         bulk_req_i;
  logic [WORD_AW-1:0]           bulk_addr_i;
  logic                         bulk_we_i;
  logic [`CR_WORD_BE_W-1:0]     bulk_be_i;
  logic [`CR_WORD_W-1:0]        bulk_wdata_i;
  logic [`CR_WORD_W-1:0]        bulk_rdata_o;

  entry_t                       table_q[$];
  logic [`CR_WORD_W-1:0]        shadow [`CR_RAM_DEPTH];
  logic [`CR_CORE_DATA_W-1:0]   ext_rdata_sent;

  data_region dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ext_req_o    (ext_req_o),
    .ext_addr_o   (ext_addr_o),
    .ext_we_o     (ext_we_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .bulk_req_i   (bulk_req_i),
    .bulk_addr_i  (bulk_addr_i),
    .bulk_we_i    (bulk_we_i),
    .bulk_be_i    (bulk_be_i),
    .bulk_wdata_i (bulk_wdata_i),
    .bulk_rdata_o (bulk_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp) else begin
      fail_run($sformatf("[ERROR] time %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic add_entry(input logic bulk, input logic we, input logic [31:0] addr,
                           input logic [7:0] be, input logic [63:0] wdata,
                           input logic [63:0] exp);
    table_q.push_back('{bulk, we, addr, be, wdata, exp});
  endtask

  task automatic load_table();
    // partial write merges into a full word
    add_entry(1'b0, 1'b1, 32'h0010_0040, 8'h0f, 64'h0000_0000_1122_3344, 64'h0);
    add_entry(1'b0, 1'b1, 32'h0010_0040, 8'h05, 64'h0000_0000_aabb_ccdd, 64'h0);
    add_entry(1'b0, 1'b0, 32'h0010_0040, 8'h0f, 64'h0, 64'h0000_0000_11bb_33dd);
    // outside region 0x001, region 0x000 included
    add_entry(1'b0, 1'b1, 32'h2000_0100, 8'h03, 64'h0000_0000_cafe_f00d, 64'h0);
    add_entry(1'b0, 1'b0, 32'h2000_0104, 8'h0f, 64'h0, 64'h0);
    add_entry(1'b0, 1'b0, 32'h000f_fffc, 8'h0f, 64'h0, 64'h0);
    // bulk word then both halves from the core
    add_entry(1'b1, 1'b1, 32'h0000_0010, 8'hff, 64'h0123_4567_89ab_cdef, 64'h0);
    add_entry(1'b0, 1'b0, 32'h0010_0080, 8'h0f, 64'h0, 64'h0000_0000_89ab_cdef);
    add_entry(1'b0, 1'b0, 32'h0010_0084, 8'h0f, 64'h0, 64'h0000_0000_0123_4567);
    // core halves then a bulk read of the whole word
    add_entry(1'b0, 1'b1, 32'h0010_0100, 8'h0f, 64'h0000_0000_dead_beef, 64'h0);
    add_entry(1'b0, 1'b1, 32'h0010_0104, 8'h0f, 64'h0000_0000_1234_5678, 64'h0);
    add_entry(1'b1, 1'b0, 32'h0000_0020, 8'h00, 64'h0, 64'h1234_5678_dead_beef);
    add_entry(1'b1, 1'b1, 32'h0000_0020, 8'h81, 64'hff00_0000_0000_0011, 64'h0);
    add_entry(1'b0, 1'b0, 32'h0010_0104, 8'h0f, 64'h0, 64'h0000_0000_ff34_5678);
    add_entry(1'b0, 1'b0, 32'h0010_0100, 8'h0f, 64'h0, 64'h0000_0000_dead_be11);
  endtask

  task automatic shadow_write(input logic [WORD_AW-1:0] word, input logic [7:0] be,
                              input logic [63:0] data);
    for (int i = 0; i < `CR_WORD_BE_W; i++) begin
      if (be[i]) begin
        shadow[word][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic core_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int gnt_waits);
    logic local_acc;
    int   waits;
    local_acc = (addr[`CR_REGION_MSB:`CR_REGION_LSB] == `CR_LOCAL_REGION);
    @(negedge clk);
    lsu_req_i   = 1'b1;
    lsu_addr_i  = addr;
    lsu_we_i    = we;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
    #(QTR);
    waits = 0;
    while (lsu_gnt_o !== 1'b1) begin
      waits++;
      assert (waits <= WAIT_LIMIT) else fail_run("lsu_gnt_o never came for a core request");
      @(negedge clk);
      #(QTR);
    end
    gnt_waits = waits;
    // fields reach the external bus unchanged
    check_value("ext_req_o", 64'(!local_acc), 64'(ext_req_o));
    if (!local_acc) begin
      check_value("ext_addr_o", 64'(addr), 64'(ext_addr_o));
      check_value("ext_we_o", 64'(we), 64'(ext_we_o));
      check_value("ext_be_o", 64'(be), 64'(ext_be_o));
      check_value("ext_wdata_o", 64'(wdata), 64'(ext_wdata_o));
    end
    @(negedge clk);
    lsu_req_i = 1'b0;
    #(QTR);
    waits = 0;
    while (lsu_rvalid_o !== 1'b1) begin
      waits++;
      assert (waits <= WAIT_LIMIT) else fail_run("lsu_rvalid_o never came after a grant");
      @(negedge clk);
      #(QTR);
    end
    // the local ram answers right after the grant cycle
    if (local_acc) begin
      assert (waits == 0) else fail_run("local response was not one cycle after the grant");
    end
    rdata = lsu_rdata_o;
  endtask

  task automatic bulk_access(input logic we, input logic [WORD_AW-1:0] word,
                             input logic [7:0] be, input logic [63:0] wdata,
                             output logic [63:0] rdata);
    @(negedge clk);
    bulk_req_i   = 1'b1;
    bulk_we_i    = we;
    bulk_addr_i  = word;
    bulk_be_i    = be;
    bulk_wdata_i = wdata;
    @(negedge clk);
    bulk_req_i = 1'b0;
    bulk_we_i  = 1'b0;
    #(QTR);
    rdata = bulk_rdata_o;
  endtask

  // external bus model, grants at once and answers after 1 to 4 cycles
  initial begin : ext_responder
    int   lat;
    logic is_read;
    void'($urandom(23));
    ext_gnt_i      = 1'b1;
    ext_rvalid_i   = 1'b0;
    ext_rdata_i    = '0;
    ext_rdata_sent = '0;
    forever begin
      @(posedge clk);
      if (rst_n && ext_req_o && ext_gnt_i) begin
        lat     = 1 + int'($urandom % 4);
        is_read = !ext_we_o;
        repeat (lat) @(negedge clk);
        ext_rvalid_i   = 1'b1;
        ext_rdata_i    = is_read ? $urandom : 32'h0;
        ext_rdata_sent = ext_rdata_i;
        @(negedge clk);
        ext_rvalid_i = 1'b0;
        ext_rdata_i  = '0;
      end
    end
  end

  initial begin : main_seq
    entry_t             e;
    logic [63:0]        rd64;
    logic [63:0]        model;
    logic [31:0]        rd32;
    logic [WORD_AW-1:0] word;
    logic               local_acc;
    int                 waits;
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_addr_i   = '0;
    lsu_we_i     = 1'b0;
    lsu_be_i     = '0;
    lsu_wdata_i  = '0;
    bulk_req_i   = 1'b0;
    bulk_addr_i  = '0;
    bulk_we_i    = 1'b0;
    bulk_be_i    = '0;
    bulk_wdata_i = '0;
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    #(QTR);
    check_value("lsu_rvalid_o", 64'd0, 64'(lsu_rvalid_o));
    check_value("lsu_gnt_o", 64'd0, 64'(lsu_gnt_o));
    check_value("ext_req_o", 64'd0, 64'(ext_req_o));

    foreach (table_q[i]) begin
      e    = table_q[i];
      word = e.addr[WORD_AW-1:0];
      if (e.bulk) begin
        bulk_access(e.we, word, e.be, e.wdata, rd64);
        if (e.we) begin
          shadow_write(word, e.be, e.wdata);
        end else begin
          model = shadow[word];
          assert (model == e.exp) else fail_run($sformatf("table row %0d disagrees", i));
          check_value("bulk_rdata_o", model, rd64);
        end
      end else begin
        core_access(e.we, e.addr, e.be[3:0], e.wdata[31:0], rd32, waits);
        local_acc = (e.addr[`CR_REGION_MSB:`CR_REGION_LSB] == `CR_LOCAL_REGION);
        word      = e.addr[`CR_RAM_ADDR_W-1:`CR_WORD_OFFS_W];
        if (local_acc) begin
          assert (waits == 0) else fail_run("local core request not granted in its own cycle");
          if (e.we) begin
            shadow_write(word, e.addr[2] ? {e.be[3:0], 4'h0} : {4'h0, e.be[3:0]},
                         {2{e.wdata[31:0]}});
          end else begin
            model = e.addr[2] ? {32'h0, shadow[word][63:32]} : {32'h0, shadow[word][31:0]};
            assert (model == e.exp) else fail_run($sformatf("table row %0d disagrees", i));
            check_value("lsu_rdata_o", model, 64'(rd32));
          end
        end else if (!e.we) begin
          check_value("lsu_rdata_o", 64'(ext_rdata_sent), 64'(rd32));
        end
      end
    end

    // bulk and core collide, the core waits out the bulk cycle
    fork
      core_access(1'b0, 32'h0010_0104, 4'hf, 32'h0, rd32, waits);
      bulk_access(1'b0, 9'h010, 8'h00, 64'h0, rd64);
    join
    check_value("bulk_rdata_o", shadow[9'h010], rd64);
    assert (waits == 1) else fail_run("core request was not held off for just the bulk cycle");
    check_value("lsu_rdata_o", 64'(shadow[9'h020][63:32]), 64'(rd32));

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/core_region_pkg.sv
hw/sp_ram.sv
hw/ram_mux.sv
hw/lsu_demux.sv
hw/data_region.sv
tb/tb_data_region.sv

// ==== run.sh ====
#!/bin/sh
# build the data region testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_data_region \
  -Mdir obj_dir -o sim_data_region
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build stopped with status $status"
  exit "$status"
fi

./obj_dir/sim_data_region
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation run ended with status $status"
  exit "$status"
fi

echo "simulation run ended with status 0"
exit 0
